/* Makefile */
.PHONY: simulate clean

simulate:
	verilator --binary --timing -j 0 --timescale 1ns/10ps --top-module tb_tinker_core -f tinker_core.f
	@out=$$(./obj_dir/Vtb_tinker_core); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* common/tinker_pkg.sv */
// Shared core definitions; unlisted opcodes (FP, divide) decode as illegal and execute as no-ops
`default_nettype none

package tinker_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    typedef logic [63:0] word_t;
    typedef logic [31:0] addr_t;    // Byte address
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] literal_t;

    localparam addr_t    reset_pc          = 32'h0000_2000;
    localparam reg_idx_t stack_reg         = 5'd31;
    localparam word_t    stack_reset_value = 64'h0000_0000_0008_0000;
    localparam addr_t    instr_bytes       = 32'd4;   // PC step
    localparam addr_t    word_bytes        = 32'd8;   // One stack slot

    // ----------------------------------------
    // Opcodes
    // ----------------------------------------
    typedef enum logic [4:0] {
        op_and     = 5'h00,
        op_or      = 5'h01,
        op_xor     = 5'h02,
        op_not     = 5'h03,
        op_shftr   = 5'h04,
        op_shftri  = 5'h05,
        op_shftl   = 5'h06,
        op_shftli  = 5'h07,
        op_br      = 5'h08,
        op_brr_reg = 5'h09,
        op_brr_lit = 5'h0a,
        op_brnz    = 5'h0b,
        op_call    = 5'h0c,
        op_return  = 5'h0d,
        op_brgt    = 5'h0e,
        op_halt    = 5'h0f,
        op_load    = 5'h10,
        op_mov_reg = 5'h11,
        op_mov_lit = 5'h12,
        op_store   = 5'h13,
        op_add     = 5'h18,
        op_addi    = 5'h19,
        op_sub     = 5'h1a,
        op_subi    = 5'h1b,
        op_mul     = 5'h1c
    } opcode_t;

    // Sequencer states, one per stage
    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_halted
    } stage_t;

    // ----------------------------------------
    // Structs
    // ----------------------------------------
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;         // Holds stack_reg for call and return
        literal_t literal;
        logic     writes_reg; // Result goes to rd in writeback
        logic     is_legal;
    } decoded_t;

    typedef struct packed {
        logic  we;            // Eight-byte big-endian write on the clock edge
        addr_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

`default_nettype wire

/* execute/execute_stage.sv */
// Integer ALU, effective address and branch decision; mul keeps the low 64 bits, shifts are logical
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  wire                   clk,
    input  wire                   reset,
    input  tinker_pkg::stage_t    stage,
    input  tinker_pkg::decoded_t  decoded,
    input  tinker_pkg::addr_t     pc,
    input  tinker_pkg::word_t     rd_val,
    input  tinker_pkg::word_t     rs_val,
    input  tinker_pkg::word_t     rt_val,
    output tinker_pkg::word_t     alu_result,
    output tinker_pkg::addr_t     mem_addr,
    output logic                  branch_taken,
    output tinker_pkg::addr_t     branch_target
);

    tinker_pkg::word_t lit_sext;
    tinker_pkg::word_t lit_zext;
    tinker_pkg::word_t alu_next;
    tinker_pkg::addr_t addr_next;
    logic              taken_next;
    tinker_pkg::addr_t target_next;

    assign lit_sext = {{52{decoded.literal[11]}}, decoded.literal};
    assign lit_zext = {52'b0, decoded.literal};

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    always_comb begin
        case (decoded.opcode)
            tinker_pkg::op_add:     alu_next = rs_val + rt_val;
            tinker_pkg::op_sub:     alu_next = rs_val - rt_val;
            tinker_pkg::op_mul:     alu_next = rs_val * rt_val;
            tinker_pkg::op_and:     alu_next = rs_val & rt_val;
            tinker_pkg::op_or:      alu_next = rs_val | rt_val;
            tinker_pkg::op_xor:     alu_next = rs_val ^ rt_val;
            tinker_pkg::op_not:     alu_next = ~rs_val;
            tinker_pkg::op_shftr:   alu_next = rs_val >> rt_val;
            tinker_pkg::op_shftl:   alu_next = rs_val << rt_val;
            tinker_pkg::op_addi:    alu_next = rd_val + lit_sext;
            tinker_pkg::op_subi:    alu_next = rd_val - lit_zext;
            tinker_pkg::op_shftri:  alu_next = rd_val >> decoded.literal;
            tinker_pkg::op_shftli:  alu_next = rd_val << decoded.literal;
            tinker_pkg::op_mov_reg: alu_next = rs_val;
            tinker_pkg::op_mov_lit: alu_next = {rd_val[63:12], decoded.literal};
            default:                alu_next = '0;
        endcase
    end

    // Effective address; rt_val is r31 for call and return
    always_comb begin
        case (decoded.opcode)
            tinker_pkg::op_load:   addr_next = rs_val[31:0] + lit_sext[31:0];
            tinker_pkg::op_store:  addr_next = rd_val[31:0] + lit_sext[31:0];
            tinker_pkg::op_call,
            tinker_pkg::op_return: addr_next = rt_val[31:0] - tinker_pkg::word_bytes;
            default:               addr_next = '0;
        endcase
    end

    // ----------------------------------------
    // Branch decision
    // ----------------------------------------
    always_comb begin
        taken_next  = 1'b0;
        target_next = rd_val[31:0];  // Absolute target for most branches
        case (decoded.opcode)
            tinker_pkg::op_br:      taken_next = 1'b1;
            tinker_pkg::op_call:    taken_next = 1'b1;
            tinker_pkg::op_brnz:    taken_next = (rs_val != '0);
            tinker_pkg::op_brgt:    taken_next = ($signed(rs_val) > $signed(rt_val));
            tinker_pkg::op_brr_reg: begin
                taken_next  = 1'b1;
                target_next = pc + rd_val[31:0];
            end
            tinker_pkg::op_brr_lit: begin
                taken_next  = 1'b1;
                target_next = pc + lit_sext[31:0];
            end
            default: taken_next = 1'b0;
        endcase
    end

    // Results held from the end of execute
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            branch_taken <= 1'b0;
        end else if (stage == tinker_pkg::st_execute) begin
            branch_taken <= taken_next;
        end
    end

    always_ff @(posedge clk) begin
        if (stage == tinker_pkg::st_execute) begin
            alu_result    <= alu_next;
            mem_addr      <= addr_next;
            branch_target <= target_next;
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch_decode_stage.sv */
// PC and instruction register; PC moves only at the end of writeback, so it freezes when halted
`timescale 1ns/10ps
`default_nettype none

module fetch_decode_stage (
    input  wire                   clk,
    input  wire                   reset,
    input  tinker_pkg::stage_t    stage,
    input  tinker_pkg::instr_t    fetch_instr,
    input  tinker_pkg::addr_t     next_pc,
    output tinker_pkg::addr_t     pc,
    output tinker_pkg::decoded_t  decoded
);

    tinker_pkg::instr_t ir;

    // ----------------------------------------
    // Program counter
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= tinker_pkg::reset_pc;
        end else if (stage == tinker_pkg::st_writeback) begin
            pc <= next_pc;
        end
    end

    // Instruction register, loaded at the end of fetch
    always_ff @(posedge clk) begin
        if (stage == tinker_pkg::st_fetch) begin
            ir <= fetch_instr;
        end
    end

    // ----------------------------------------
    // Field split and opcode classes
    // ----------------------------------------
    always_comb begin
        decoded.opcode     = tinker_pkg::opcode_t'(ir[31:27]);
        decoded.rd         = ir[26:22];
        decoded.rs         = ir[21:17];
        decoded.rt         = ir[16:12];
        decoded.literal    = ir[11:0];
        decoded.writes_reg = 1'b0;
        decoded.is_legal   = 1'b1;

        case (decoded.opcode)
            tinker_pkg::op_and, tinker_pkg::op_or, tinker_pkg::op_xor,
            tinker_pkg::op_not, tinker_pkg::op_shftr, tinker_pkg::op_shftri,
            tinker_pkg::op_shftl, tinker_pkg::op_shftli, tinker_pkg::op_mov_reg,
            tinker_pkg::op_mov_lit, tinker_pkg::op_load, tinker_pkg::op_add,
            tinker_pkg::op_addi, tinker_pkg::op_sub, tinker_pkg::op_subi,
            tinker_pkg::op_mul: begin
                decoded.writes_reg = 1'b1;
            end
            tinker_pkg::op_call, tinker_pkg::op_return: begin
                // rt is unused by these, so its read port carries the stack pointer
                decoded.rt = tinker_pkg::stack_reg;
            end
            tinker_pkg::op_br, tinker_pkg::op_brr_reg, tinker_pkg::op_brr_lit,
            tinker_pkg::op_brnz, tinker_pkg::op_brgt, tinker_pkg::op_halt,
            tinker_pkg::op_store: begin
                decoded.writes_reg = 1'b0;  // No register result
            end
            default: begin
                decoded.is_legal = 1'b0;    // FP, divide and unused codes
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/memory_stage.sv */
// Data access, next-PC select and writeback data; memory must return load_data in the same cycle
`timescale 1ns/10ps
`default_nettype none

module memory_stage (
    input  wire                   clk,
    input  wire                   reset,
    input  tinker_pkg::stage_t    stage,
    input  tinker_pkg::decoded_t  decoded,
    input  tinker_pkg::addr_t     pc,
    input  tinker_pkg::word_t     alu_result,
    input  tinker_pkg::addr_t     mem_addr,
    input  logic                  branch_taken,
    input  tinker_pkg::addr_t     branch_target,
    input  tinker_pkg::word_t     rs_val,
    input  tinker_pkg::word_t     load_data,
    output tinker_pkg::mem_req_t  data_req,
    output tinker_pkg::addr_t     next_pc,
    output tinker_pkg::word_t     wb_data,
    output logic                  wb_en
);

    tinker_pkg::addr_t seq_pc;
    logic              in_memory;

    assign seq_pc    = pc + tinker_pkg::instr_bytes;   // Fall-through and call return address
    assign in_memory = (stage == tinker_pkg::st_memory);

    // ----------------------------------------
    // Data request
    // ----------------------------------------
    always_comb begin
        data_req.addr = mem_addr;
        if (decoded.opcode == tinker_pkg::op_call) begin
            data_req.wdata = {32'b0, seq_pc};
        end else begin
            data_req.wdata = rs_val;
        end
        data_req.we = in_memory && ((decoded.opcode == tinker_pkg::op_store) ||
                                    (decoded.opcode == tinker_pkg::op_call));
    end

    // Next PC, taken into the PC at the end of writeback
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            next_pc <= tinker_pkg::reset_pc;
        end else if (in_memory) begin
            if (decoded.opcode == tinker_pkg::op_return) begin
                next_pc <= load_data[31:0];  // Saved return address
            end else if (branch_taken) begin
                next_pc <= branch_target;
            end else begin
                next_pc <= seq_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_memory) begin
            wb_data <= (decoded.opcode == tinker_pkg::op_load) ? load_data : alu_result;
        end
    end

    assign wb_en = (stage == tinker_pkg::st_writeback) && decoded.writes_reg && decoded.is_legal;

endmodule

`default_nettype wire

/* hdl/register_file.sv */
// 32 x 64-bit registers; r0 is writable like any other, and reads see the old value until the edge
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  wire                   clk,
    input  wire                   reset,
    input  logic                  write_en,
    input  tinker_pkg::reg_idx_t  write_idx,
    input  tinker_pkg::word_t     write_data,
    input  tinker_pkg::reg_idx_t  rd_idx,
    input  tinker_pkg::reg_idx_t  rs_idx,
    input  tinker_pkg::reg_idx_t  rt_idx,
    output tinker_pkg::word_t     rd_val,
    output tinker_pkg::word_t     rs_val,
    output tinker_pkg::word_t     rt_val
);

    tinker_pkg::word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            regs[tinker_pkg::stack_reg] <= tinker_pkg::stack_reset_value;  // Top of stack
        end else if (write_en) begin
            regs[write_idx] <= write_data;
        end
    end

    // Combinational read ports
    assign rd_val = regs[rd_idx];
    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];

endmodule

`default_nettype wire

/* hdl/stage_sequencer.sv */
// Five-state stepper plus a halted state that only reset leaves; no stall input exists
`timescale 1ns/10ps
`default_nettype none

module stage_sequencer (
    input  wire                   clk,
    input  wire                   reset,
    input  tinker_pkg::decoded_t  decoded,
    output tinker_pkg::stage_t    stage,
    output logic                  hlt
);

    tinker_pkg::stage_t stage_next;

    // Next stage
    always_comb begin
        case (stage)
            tinker_pkg::st_fetch: begin
                stage_next = tinker_pkg::st_decode;
            end
            tinker_pkg::st_decode: begin
                // Halt is seen as soon as the instruction register is decoded
                if (decoded.opcode == tinker_pkg::op_halt) begin
                    stage_next = tinker_pkg::st_halted;
                end else begin
                    stage_next = tinker_pkg::st_execute;
                end
            end
            tinker_pkg::st_execute:   stage_next = tinker_pkg::st_memory;
            tinker_pkg::st_memory:    stage_next = tinker_pkg::st_writeback;
            tinker_pkg::st_writeback: stage_next = tinker_pkg::st_fetch;
            tinker_pkg::st_halted:    stage_next = tinker_pkg::st_halted;  // Sticky
            default:                  stage_next = tinker_pkg::st_fetch;
        endcase
    end

    // ----------------------------------------
    // State and halt flag
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage <= tinker_pkg::st_fetch;
            hlt   <= 1'b0;
        end else begin
            stage <= stage_next;
            hlt   <= (stage_next == tinker_pkg::st_halted);  // Tracks halted exactly
        end
    end

endmodule

`default_nettype wire

/* hdl/tinker_core.sv */
// Core top; expects memory that answers fetch and load in the same cycle, one instruction per 5 cycles
`timescale 1ns/10ps
`default_nettype none

module tinker_core (
    input  wire                   clk,
    input  wire                   reset,
    output tinker_pkg::addr_t     fetch_addr,   // Also the core's PC
    input  tinker_pkg::instr_t    fetch_instr,
    output tinker_pkg::mem_req_t  data_req,
    input  tinker_pkg::word_t     load_data,
    output logic                  hlt
);

    tinker_pkg::stage_t   stage;
    tinker_pkg::decoded_t decoded;
    tinker_pkg::addr_t    next_pc;

    tinker_pkg::word_t    rd_val;
    tinker_pkg::word_t    rs_val;
    tinker_pkg::word_t    rt_val;

    tinker_pkg::word_t    alu_result;
    tinker_pkg::addr_t    mem_addr;
    logic                 branch_taken;
    tinker_pkg::addr_t    branch_target;

    tinker_pkg::word_t    wb_data;
    logic                 wb_en;

    // ----------------------------------------
    // Control
    // ----------------------------------------
    stage_sequencer u_sequencer (
        .clk     (clk),
        .reset   (reset),
        .decoded (decoded),
        .stage   (stage),
        .hlt     (hlt)
    );

    fetch_decode_stage u_fetch_decode (
        .clk         (clk),
        .reset       (reset),
        .stage       (stage),
        .fetch_instr (fetch_instr),
        .next_pc     (next_pc),
        .pc          (fetch_addr),
        .decoded     (decoded)
    );

    register_file u_regs (
        .clk        (clk),
        .reset      (reset),
        .write_en   (wb_en),
        .write_idx  (decoded.rd),
        .write_data (wb_data),
        .rd_idx     (decoded.rd),
        .rs_idx     (decoded.rs),
        .rt_idx     (decoded.rt),
        .rd_val     (rd_val),
        .rs_val     (rs_val),
        .rt_val     (rt_val)
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    execute_stage u_execute (
        .clk           (clk),
        .reset         (reset),
        .stage         (stage),
        .decoded       (decoded),
        .pc            (fetch_addr),
        .rd_val        (rd_val),
        .rs_val        (rs_val),
        .rt_val        (rt_val),
        .alu_result    (alu_result),
        .mem_addr      (mem_addr),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    memory_stage u_memory (
        .clk           (clk),
        .reset         (reset),
        .stage         (stage),
        .decoded       (decoded),
        .pc            (fetch_addr),
        .alu_result    (alu_result),
        .mem_addr      (mem_addr),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .rs_val        (rs_val),
        .load_data     (load_data),
        .data_req      (data_req),
        .next_pc       (next_pc),
        .wb_data       (wb_data),
        .wb_en         (wb_en)
    );

endmodule

`default_nettype wire

/* tinker_core.f */
common/tinker_pkg.sv
hdl/stage_sequencer.sv
hdl/fetch_decode_stage.sv
hdl/register_file.sv
execute/execute_stage.sv
hdl/memory_stage.sv
hdl/tinker_core.sv
verification/tb_memory_model.sv
verification/tb_tinker_core.sv

/* verification/tb_memory_model.sv */
// Byte memory for simulation only; 1 MB mirrored on addr[19:0], host port writes only while the core is in reset
`timescale 1ns/10ps
`default_nettype none

module tb_memory_model (
    input  wire                   clk,
    input  logic                  clear,        // Zero the whole array on the edge
    input  logic                  host_we,      // Program load, one instruction per cycle
    input  tinker_pkg::addr_t     host_addr,
    input  tinker_pkg::instr_t    host_instr,
    input  tinker_pkg::addr_t     fetch_addr,
    output tinker_pkg::instr_t    fetch_instr,
    input  tinker_pkg::mem_req_t  data_req,
    output tinker_pkg::word_t     load_data,
    input  tinker_pkg::addr_t     peek_addr,
    output tinker_pkg::word_t     peek_data
);

    localparam int mem_size = 1 << 20;

    logic [7:0]        bytes [mem_size];
    tinker_pkg::word_t fetch_word;

    function automatic logic [19:0] idx(tinker_pkg::addr_t a);
        return a[19:0];
    endfunction

    // Eight bytes from a, first byte in the top bits
    function automatic tinker_pkg::word_t word_at(tinker_pkg::addr_t a);
        tinker_pkg::word_t w;
        w = '0;
        for (int k = 0; k < 8; k++) begin
            w = {w[55:0], bytes[idx(a + tinker_pkg::addr_t'(k))]};
        end
        return w;
    endfunction

    // ----------------------------------------
    // Same-cycle read ports
    // ----------------------------------------
    always_comb begin
        fetch_word  = word_at(fetch_addr);
        fetch_instr = fetch_word[63:32];
        load_data   = word_at(data_req.addr);
        peek_data   = word_at(peek_addr);
    end

    // Single writer for the array
    always @(posedge clk) begin
        if (clear) begin
            for (int i = 0; i < mem_size; i++) begin
                bytes[i] = 8'h00;
            end
        end else if (host_we) begin
            for (int k = 0; k < 4; k++) begin
                bytes[idx(host_addr + tinker_pkg::addr_t'(k))] = host_instr[31 - 8 * k -: 8];
            end
        end else if (data_req.we) begin
            for (int k = 0; k < 8; k++) begin   // Big-endian store
                bytes[idx(data_req.addr + tinker_pkg::addr_t'(k))] =
                    data_req.wdata[63 - 8 * k -: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_tinker_core.sv */
// Directed tests of the core; data area at 0x10000 through r10, programs start at 0x2000
`timescale 1ns/10ps
`default_nettype none

module tb_tinker_core;

    logic                 clk;
    logic                 reset;
    logic                 clear;
    logic                 host_we;
    tinker_pkg::addr_t    host_addr;
    tinker_pkg::instr_t   host_instr;
    tinker_pkg::addr_t    peek_addr;
    tinker_pkg::word_t    peek_data;
    tinker_pkg::addr_t    fetch_addr;
    tinker_pkg::instr_t   fetch_instr;
    tinker_pkg::mem_req_t data_req;
    tinker_pkg::word_t    load_data;
    logic                 hlt;

    integer               seed = 32'h4c99ab8b;
    int                   errors = 0;
    int                   checks = 0;
    int                   store_count = 0;
    tinker_pkg::instr_t   prog [$];
    int                   exp_off [$];
    tinker_pkg::word_t    exp_val [$];

    tinker_core u_dut (
        .clk         (clk),
        .reset       (reset),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr),
        .data_req    (data_req),
        .load_data   (load_data),
        .hlt         (hlt)
    );

    tb_memory_model u_mem (
        .clk         (clk),
        .clear       (clear),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_instr  (host_instr),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr),
        .data_req    (data_req),
        .load_data   (load_data),
        .peek_addr   (peek_addr),
        .peek_data   (peek_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!reset && data_req.we) store_count++;
    end

    // ----------------------------------------
    // Program building
    // ----------------------------------------
    function automatic tinker_pkg::instr_t enc(tinker_pkg::opcode_t op, int rd, int rs,
                                               int rt, int lit);
        return {op, rd[4:0], rs[4:0], rt[4:0], lit[11:0]};
    endfunction

    function automatic tinker_pkg::addr_t pc_now();
        return 32'h2000 + 32'(4 * prog.size());
    endfunction

    task automatic emit(tinker_pkg::instr_t i);
        prog.push_back(i);
    endtask

    // Fixed length of 11 instructions whatever the old register value
    task automatic load_const(int r, tinker_pkg::word_t v);
        emit(enc(tinker_pkg::op_mov_lit, r, 0, 0, int'(v[63:60])));
        for (int k = 4; k >= 0; k--) begin
            emit(enc(tinker_pkg::op_shftli, r, 0, 0, 12));
            emit(enc(tinker_pkg::op_mov_lit, r, 0, 0, int'(v[12 * k +: 12])));
        end
    endtask

    task automatic store_expect(int rs, int off, tinker_pkg::word_t v);
        emit(enc(tinker_pkg::op_store, 10, rs, 0, off));
        exp_off.push_back(off);
        exp_val.push_back(v);
    endtask

    task automatic rand_word(output tinker_pkg::word_t w);
        w = {$random(seed), $random(seed)};
    endtask

    task automatic start_test();
        prog.delete();
        exp_off.delete();
        exp_val.delete();
        load_const(10, 64'h1_0000);   // Data base
    endtask

    // ----------------------------------------
    // Run control and checking
    // ----------------------------------------
    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    task automatic abort_run(string what);
        errors++;
        $display("Timeout: %s did not happen in time", what);
        finish_run();
    endtask

    task automatic check_word(string what, tinker_pkg::word_t got, tinker_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic read_word(tinker_pkg::addr_t a, output tinker_pkg::word_t w);
        peek_addr = a;
        #1;
        w = peek_data;
    endtask

    // Core held in reset while the program goes in
    task automatic load_program();
        reset = 1'b1;
        clear = 1'b1;
        @(posedge clk);
        #1;
        clear = 1'b0;
        foreach (prog[i]) begin
            host_we    = 1'b1;
            host_addr  = 32'h2000 + 32'(4 * i);
            host_instr = prog[i];
            @(posedge clk);
            #1;
        end
        host_we = 1'b0;
    endtask

    task automatic reset_dut();
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        check_word("hlt in reset", 64'(hlt), 64'd0);
        check_word("fetch_addr in reset", 64'(fetch_addr), 64'h2000);
        check_word("store strobe in reset", 64'(data_req.we), 64'd0);
        reset = 1'b0;
    endtask

    task automatic wait_halt();
        int n;
        n = 0;
        while (!hlt && n < 5000) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!hlt) abort_run("hlt");
    endtask

    task automatic check_stores();
        tinker_pkg::word_t w;
        foreach (exp_off[i]) begin
            read_word(32'h1_0000 + 32'(exp_off[i]), w);
            check_word($sformatf("word at offset %0h", exp_off[i]), w, exp_val[i]);
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic reset_state_test();
        int n;
        prog.delete();
        emit(enc(tinker_pkg::op_mov_lit, 1, 0, 0, 1));
        emit(enc(tinker_pkg::op_halt, 0, 0, 0, 0));
        load_program();
        reset_dut();
        n = 0;
        while (fetch_addr == 32'h2000 && n < 50) begin
            @(posedge clk);
            #1;
            n++;
            check_word("hlt after release", 64'(hlt), 64'd0);
            check_word("store strobe after release", 64'(data_req.we), 64'd0);
        end
        if (fetch_addr == 32'h2000) begin
            abort_run("first fetch_addr change");
        end else begin
            check_word("cycles to first pc step", 64'(n), 64'd5);
            check_word("second fetch_addr", 64'(fetch_addr), 64'h2004);
            wait_halt();
        end
    endtask

    task automatic arith_logic_test();
        tinker_pkg::word_t a;
        tinker_pkg::word_t b;
        tinker_pkg::word_t l;
        rand_word(a);
        rand_word(b);
        rand_word(l);
        start_test();
        load_const(1, a);
        load_const(2, b);
        emit(enc(tinker_pkg::op_add, 3, 1, 2, 0));
        store_expect(3, 0, a + b);
        emit(enc(tinker_pkg::op_sub, 3, 1, 2, 0));
        store_expect(3, 8, a - b);
        emit(enc(tinker_pkg::op_mul, 3, 1, 2, 0));
        store_expect(3, 16, a * b);
        emit(enc(tinker_pkg::op_and, 3, 1, 2, 0));
        store_expect(3, 24, a & b);
        emit(enc(tinker_pkg::op_or, 3, 1, 2, 0));
        store_expect(3, 32, a | b);
        emit(enc(tinker_pkg::op_xor, 3, 1, 2, 0));
        store_expect(3, 40, a ^ b);
        emit(enc(tinker_pkg::op_not, 3, 1, 0, 0));
        store_expect(3, 48, ~a);
        emit(enc(tinker_pkg::op_mov_reg, 3, 1, 0, 0));
        emit(enc(tinker_pkg::op_addi, 3, 0, 0, int'(l[11:0])));
        store_expect(3, 56, a + {{52{l[11]}}, l[11:0]});   // Signed literal
        emit(enc(tinker_pkg::op_mov_reg, 3, 1, 0, 0));
        emit(enc(tinker_pkg::op_subi, 3, 0, 0, int'(l[11:0])));
        store_expect(3, 64, a - {52'b0, l[11:0]});         // Unsigned literal
        emit(enc(tinker_pkg::op_halt, 0, 0, 0, 0));
        load_program();
        reset_dut();
        wait_halt();
        check_stores();
    endtask

    task automatic shift_move_test();
        tinker_pkg::word_t a;
        tinker_pkg::word_t b;
        tinker_pkg::word_t s;
        tinker_pkg::word_t w;
        rand_word(a);
        rand_word(b);
        rand_word(s);
        s = {58'b0, s[5:0]};
        start_test();
        load_const(1, a);
        load_const(2, b);
        load_const(5, s);
        emit(enc(tinker_pkg::op_shftr, 3, 1, 5, 0));
        store_expect(3, 0, a >> s);
        emit(enc(tinker_pkg::op_shftl, 3, 1, 5, 0));
        store_expect(3, 8, a << s);
        emit(enc(tinker_pkg::op_mov_reg, 3, 1, 0, 0));
        emit(enc(tinker_pkg::op_shftri, 3, 0, 0, int'(s[5:0])));
        store_expect(3, 16, a >> s);
        emit(enc(tinker_pkg::op_mov_reg, 3, 1, 0, 0));
        emit(enc(tinker_pkg::op_shftli, 3, 0, 0, int'(s[5:0])));
        store_expect(3, 24, a << s);
        emit(enc(tinker_pkg::op_mov_reg, 3, 2, 0, 0));
        store_expect(3, 32, b);
        emit(enc(tinker_pkg::op_mov_reg, 3, 1, 0, 0));
        emit(enc(tinker_pkg::op_mov_lit, 3, 0, 0, int'(b[11:0])));
        store_expect(3, 40, {a[63:12], b[11:0]});
        emit(enc(tinker_pkg::op_halt, 0, 0, 0, 0));
        load_program();
        reset_dut();
        wait_halt();
        check_stores();
        // First byte in memory is the top byte
        read_word(32'h1_0020, w);
        check_word("byte at offset 20", 64'(w[63:56]), 64'(b[63:56]));
        read_word(32'h1_0027, w);
        check_word("byte at offset 27", 64'(w[63:56]), 64'(b[7:0]));
    endtask

    // Fall slot written only when not taken, taken slot always reached
    task automatic branch_case(tinker_pkg::opcode_t op, int rs, int rt, tinker_pkg::word_t rd_v,
                               int lit, int off, logic taken, tinker_pkg::word_t m);
        load_const(20, rd_v);
        emit(enc(op, 20, rs, rt, lit));
        store_expect(21, off, taken ? 64'd0 : m);
        store_expect(21, off + 8, m);
    endtask

    task automatic load_branch_test();
        tinker_pkg::word_t a;
        tinker_pkg::word_t b;
        tinker_pkg::word_t m;
        tinker_pkg::word_t neg;
        rand_word(a);
        rand_word(b);
        rand_word(m);
        neg = -64'd5;
        start_test();
        load_const(1, a);
        load_const(2, b);
        load_const(3, neg);
        load_const(21, m);
        emit(enc(tinker_pkg::op_store, 10, 1, 0, 256));
        emit(enc(tinker_pkg::op_load, 4, 10, 0, 256));
        store_expect(4, 264, a);
        branch_case(tinker_pkg::op_brnz, 1, 0, 64'(pc_now() + 52), 0, 512, a != 0, m);
        branch_case(tinker_pkg::op_brnz, 0, 0, 64'(pc_now() + 52), 0, 528, 1'b0, m);
        branch_case(tinker_pkg::op_brgt, 1, 2, 64'(pc_now() + 52), 0, 544,
                    $signed(a) > $signed(b), m);
        branch_case(tinker_pkg::op_brgt, 3, 0, 64'(pc_now() + 52), 0, 560, 1'b0, m);
        branch_case(tinker_pkg::op_brgt, 0, 3, 64'(pc_now() + 52), 0, 576, 1'b1, m);
        branch_case(tinker_pkg::op_brgt, 1, 1, 64'(pc_now() + 52), 0, 592, 1'b0, m);
        branch_case(tinker_pkg::op_br, 0, 0, 64'(pc_now() + 52), 0, 608, 1'b1, m);
        branch_case(tinker_pkg::op_brr_reg, 0, 0, 64'd8, 0, 624, 1'b1, m);
        branch_case(tinker_pkg::op_brr_lit, 0, 0, 64'd0, 8, 640, 1'b1, m);
        emit(enc(tinker_pkg::op_halt, 0, 0, 0, 0));
        load_program();
        reset_dut();
        wait_halt();
        check_stores();
    endtask

    task automatic call_return_halt_test();
        tinker_pkg::word_t m;
        tinker_pkg::word_t w;
        tinker_pkg::addr_t call_pc;
        tinker_pkg::addr_t halt_pc;
        int                n;
        int                stores;
        rand_word(m);
        start_test();
        load_const(21, m);
        load_const(5, 64'h2400);       // Subroutine address
        call_pc = pc_now();
        emit(enc(tinker_pkg::op_call, 5, 0, 0, 0));
        store_expect(21, 768, m);      // Reached only through return
        halt_pc = pc_now();
        emit(enc(tinker_pkg::op_halt, 0, 0, 0, 0));
        while (pc_now() != 32'h2400) emit(enc(tinker_pkg::op_halt, 0, 0, 0, 0));
        emit(enc(tinker_pkg::op_return, 0, 0, 0, 0));
        load_program();
        reset_dut();
        n = 0;
        while (fetch_addr != halt_pc && n < 5000) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (fetch_addr != halt_pc) abort_run("fetch of halt");
        n = 0;
        while (!hlt && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        check_word("cycles from halt fetch to hlt", 64'(n), 64'd2);
        stores = store_count;
        repeat (20) begin
            @(posedge clk);
            #1;
            check_word("fetch_addr while halted", 64'(fetch_addr), 64'(halt_pc));
        end
        check_word("stores while halted", 64'(store_count), 64'(stores));
        read_word(32'h8_0000 - 32'd8, w);
        check_word("saved return address", w, {32'b0, call_pc + 32'd4});
        check_stores();
    endtask

    initial begin
        reset      = 1'b1;
        clear      = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_instr = '0;
        peek_addr  = '0;
        #1;
        reset_state_test();
        arith_logic_test();
        shift_move_test();
        load_branch_test();
        call_return_halt_test();
        finish_run();
    end

endmodule

`default_nettype wire
